// ==== Makefile ====
# Verilator build and run for the read request subsystem testbench

TOP := tb_hc_read_subsystem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f sim.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)
	verilator --lint-only -f sim.f --top-module hc_read_subsystem

clean:
	rm -rf obj_dir sim.log

// ==== hdl/hc_defs.svh ====
/*
 * Host-memory traffic driver read path
 * Widths and timing constants shared by the package and the RTL
 */

`ifndef HC_DEFS_SVH
`define HC_DEFS_SVH

// Width of a line address on the memory read channel
`define HC_ADDR_WIDTH 32

// The request tag holds a 2-bit source id above a 6-bit line count
`define HC_TAG_WIDTH 8

// Cycles between two status-line reads
`define HC_STATUS_PERIOD 16

// Requests still allowed to issue once the channel reports almost-full
`define HC_AF_SLACK 2

`endif

// ==== hdl/hc_issue_throttle.sv ====
/*
 * Issue throttle for the memory read channel
 * Lets a few requests through after almost-full rises, then holds issue
 */

`timescale 1ns/1ns
`default_nettype none

`include "hc_defs.svh"

module hc_issue_throttle
(
    input  wire  clk,
    input  wire  reset,
    input  logic almost_full,
    input  logic issue,
    output logic can_issue
);

    // The count never exceeds the slack, so it only needs to hold that value
    localparam int CNT_W = $clog2(`HC_AF_SLACK + 1);

    logic [CNT_W-1:0] af_issue_cnt;

    // Requests already in flight when almost-full rises still land, so the
    // channel gets a little slack before issue stops
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            af_issue_cnt <= '0;
        end
        else if (!almost_full)
        begin
            // The channel has room again, so the slack is restored in full
            af_issue_cnt <= '0;
        end
        else if (issue && (af_issue_cnt < CNT_W'(`HC_AF_SLACK)))
        begin
            af_issue_cnt <= af_issue_cnt + 1'b1;
        end
    end

    // Free issue while the channel has room, otherwise only within the slack
    always_comb
    begin
        can_issue = !almost_full || (af_issue_cnt < CNT_W'(`HC_AF_SLACK));
    end

endmodule

`default_nettype wire

// ==== hdl/hc_line_streamer.sv ====
/*
 * Line streamer for one buffer region
 * Issues one line read per grant until buf_lines lines are done
 */

`timescale 1ns/1ns
`default_nettype none

`include "hc_defs.svh"

module hc_line_streamer
    import hc_pkg::*;
#(
    parameter logic [1:0] SOURCE_ID = 2'd0
)
(
    input  wire                        clk,
    input  wire                        reset,
    input  logic                       hc_en,
    input  logic [`HC_ADDR_WIDTH-1:0]  base_addr,
    input  logic [`HC_ADDR_WIDTH-1:0]  buf_lines,
    hc_read_req_if.requester           req,
    output logic                       done
);

    // Low tag bits carry the line count below the source id
    localparam int LINE_CNT_W = `HC_TAG_WIDTH - 2;

    logic [`HC_ADDR_WIDTH-1:0] line_idx;
    logic                      active;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            line_idx <= '0;
            active   <= 1'b0;
            done     <= 1'b0;
        end
        else if (!hc_en)
        begin
            // Dropping the enable rearms the region from its first line
            line_idx <= '0;
            active   <= 1'b0;
            done     <= 1'b0;
        end
        else if (active)
        begin
            // Step to the next line on the same edge that takes the grant
            if (req.grant)
            begin
                line_idx <= line_idx + 1'b1;
                if ((line_idx + 1'b1) == buf_lines)
                begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
        else if (!done)
        begin
            // An empty region finishes at once without any read
            if (buf_lines == '0)
                done <= 1'b1;
            else
                active <= 1'b1;
        end
    end

    // The request stays up between grants, so the next line follows at once
    assign req.request = active;

    // Header for the current line
    assign req.hdr = '{addr:     base_addr + line_idx,
                       tag:      {SOURCE_ID, line_idx[LINE_CNT_W-1:0]},
                       req_type: HC_REQ_LINE_READ};

endmodule

`default_nettype wire

// ==== hdl/hc_pkg.sv ====
/*
 * Types for the host-memory read request path
 * Holds the request header, its type field and the grant bundle
 */

`default_nettype none

`include "hc_defs.svh"

package hc_pkg;

    // Request type of a read on the channel
    typedef enum logic
    {
        HC_REQ_NONE      = 1'b0,
        HC_REQ_LINE_READ = 1'b1
    } hc_req_type_t;

    // Every read request carries this 41-bit header
    typedef struct packed
    {
        logic [`HC_ADDR_WIDTH-1:0] addr;
        logic [`HC_TAG_WIDTH-1:0]  tag;
        hc_req_type_t              req_type;
    } hc_req_hdr_t;

    // Grant bits of the arbiter, one per requester, plus the issue permission
    typedef struct packed
    {
        logic reader_grant;
        logic writer_grant;
        logic status_grant;
        logic can_issue;
    } hc_read_grant_t;

endpackage

`default_nettype wire

// ==== hdl/hc_read_arbiter.sv ====
/*
 * Read arbiter for the memory read channel
 * Alternates the frame reader and writer, serves status last and
 * registers the chosen header onto the channel
 */

`timescale 1ns/1ns
`default_nettype none

module hc_read_arbiter
    import hc_pkg::*;
(
    input  wire                  clk,
    input  wire                  reset,
    input  logic                 hc_en,
    hc_read_req_if.arbiter       reader,
    hc_read_req_if.arbiter       writer,
    hc_read_req_if.arbiter       status,
    input  logic                 tx_almost_full,
    output logic                 tx_rd_valid,
    output hc_req_hdr_t          tx_hdr
);

    typedef enum logic
    {
        FAVOR_READER,
        FAVOR_WRITER
    } arb_state_t;

    arb_state_t     state;
    hc_read_grant_t grant;
    logic           throttle_ok;
    logic           rd_valid;
    hc_req_hdr_t    hdr_sel;
    hc_req_hdr_t    hdr_next;

    // Issue is allowed only when the channel has room and software enables it
    hc_issue_throttle u_throttle
    (
        .clk         (clk),
        .reset       (reset),
        .almost_full (tx_almost_full),
        .issue       (grant.reader_grant | grant.writer_grant | grant.status_grant),
        .can_issue   (throttle_ok)
    );

    // After serving the reader the writer goes first, any other cycle
    // returns the preference to the reader
    always_ff @(posedge clk)
    begin
        if (reset)
            state <= FAVOR_READER;
        else if (grant.reader_grant)
            state <= FAVOR_WRITER;
        else
            state <= FAVOR_READER;
    end

    always_comb
    begin
        grant.can_issue    = throttle_ok && hc_en;
        grant.reader_grant = 1'b0;
        grant.writer_grant = 1'b0;
        grant.status_grant = 1'b0;
        rd_valid           = 1'b0;

        // With no grant the reader header passes through and the type field
        // below marks it as no request
        hdr_sel = reader.hdr;

        if (reader.request && (state == FAVOR_READER || !writer.request))
        begin
            grant.reader_grant = grant.can_issue;
            rd_valid           = grant.can_issue;
        end
        else if (writer.request)
        begin
            hdr_sel            = writer.hdr;
            grant.writer_grant = grant.can_issue;
            rd_valid           = grant.can_issue;
        end
        else if (status.request)
        begin
            hdr_sel            = status.hdr;
            grant.status_grant = grant.can_issue;
            rd_valid           = grant.can_issue;
        end
    end

    // The type field follows the valid, so an idle cycle shows no request
    always_comb
    begin
        hdr_next = hdr_sel;
        if (!rd_valid)
            hdr_next.req_type = HC_REQ_NONE;
    end

    assign reader.grant     = grant.reader_grant;
    assign writer.grant     = grant.writer_grant;
    assign status.grant     = grant.status_grant;
    assign reader.can_issue = grant.can_issue;
    assign writer.can_issue = grant.can_issue;
    assign status.can_issue = grant.can_issue;

    // One request per cycle leaves through this register
    always_ff @(posedge clk)
    begin
        if (reset)
            tx_rd_valid <= 1'b0;
        else
            tx_rd_valid <= rd_valid;
        tx_hdr <= hdr_next;
    end

endmodule

`default_nettype wire

// ==== hdl/hc_read_req_if.sv ====
/*
 * Read request link between one requester and the read arbiter
 * Request level and header go one way, the same-cycle grant comes back
 */

`timescale 1ns/1ns
`default_nettype none

interface hc_read_req_if
    import hc_pkg::*;
    ;

    // Held high with a stable header until a grant is seen at a clock edge
    logic        request;
    hc_req_hdr_t hdr;

    // Combinational grant from the arbiter
    logic        grant;

    // The arbiter's issue permission, passed back so requesters can see it
    logic        can_issue;

    modport requester
    (
        output request,
        output hdr,
        input  grant,
        input  can_issue
    );

    modport arbiter
    (
        input  request,
        input  hdr,
        output grant,
        output can_issue
    );

endinterface

`default_nettype wire

// ==== hdl/hc_read_subsystem.sv ====
/*
 * Read request subsystem of the host-memory traffic driver
 * Frame reader, frame writer and status poller share one read channel
 */

`timescale 1ns/1ns
`default_nettype none

`include "hc_defs.svh"

module hc_read_subsystem
    import hc_pkg::*;
(
    input  wire                        clk,
    input  wire                        reset,
    input  logic                       hc_en,
    input  logic [`HC_ADDR_WIDTH-1:0]  reader_base,
    input  logic [`HC_ADDR_WIDTH-1:0]  writer_base,
    input  logic [`HC_ADDR_WIDTH-1:0]  buf_lines,
    input  logic [`HC_ADDR_WIDTH-1:0]  status_addr,
    input  logic                       tx_almost_full,
    output logic                       tx_rd_valid,
    output logic [`HC_ADDR_WIDTH-1:0]  tx_addr,
    output logic [`HC_TAG_WIDTH-1:0]   tx_tag,
    output hc_req_type_t               tx_req_type,
    output logic                       reader_done,
    output logic                       writer_done
);

    hc_read_req_if reader_req ();
    hc_read_req_if writer_req ();
    hc_read_req_if status_req ();

    hc_req_hdr_t tx_hdr;

    // Frame reader walks its buffer as source 0
    hc_line_streamer #(.SOURCE_ID(2'd0)) u_reader
    (
        .clk       (clk),
        .reset     (reset),
        .hc_en     (hc_en),
        .base_addr (reader_base),
        .buf_lines (buf_lines),
        .req       (reader_req.requester),
        .done      (reader_done)
    );

    // Frame writer reads its buffer as source 1
    hc_line_streamer #(.SOURCE_ID(2'd1)) u_writer
    (
        .clk       (clk),
        .reset     (reset),
        .hc_en     (hc_en),
        .base_addr (writer_base),
        .buf_lines (buf_lines),
        .req       (writer_req.requester),
        .done      (writer_done)
    );

    hc_status_poller u_status
    (
        .clk         (clk),
        .reset       (reset),
        .hc_en       (hc_en),
        .status_addr (status_addr),
        .req         (status_req.requester)
    );

    hc_read_arbiter u_arbiter
    (
        .clk            (clk),
        .reset          (reset),
        .hc_en          (hc_en),
        .reader         (reader_req.arbiter),
        .writer         (writer_req.arbiter),
        .status         (status_req.arbiter),
        .tx_almost_full (tx_almost_full),
        .tx_rd_valid    (tx_rd_valid),
        .tx_hdr         (tx_hdr)
    );

    // Header fields go out as separate ports
    assign tx_addr     = tx_hdr.addr;
    assign tx_tag      = tx_hdr.tag;
    assign tx_req_type = tx_hdr.req_type;

endmodule

`default_nettype wire

// ==== hdl/hc_status_poller.sv ====
/*
 * Status poller
 * Reads the status line once every poll period while the driver is enabled
 */

`timescale 1ns/1ns
`default_nettype none

`include "hc_defs.svh"

module hc_status_poller
    import hc_pkg::*;
(
    input  wire                        clk,
    input  wire                        reset,
    input  logic                       hc_en,
    input  logic [`HC_ADDR_WIDTH-1:0]  status_addr,
    hc_read_req_if.requester           req
);

    localparam int PERIOD_W   = $clog2(`HC_STATUS_PERIOD);
    localparam int POLL_CNT_W = `HC_TAG_WIDTH - 2;

    logic [PERIOD_W-1:0]   period_cnt;
    logic                  pending;
    logic [POLL_CNT_W-1:0] poll_cnt;
    logic                  expire;

    // Last cycle of the poll period
    assign expire = hc_en && (period_cnt == PERIOD_W'(`HC_STATUS_PERIOD - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            period_cnt <= '0;
            pending    <= 1'b0;
            poll_cnt   <= '0;
        end
        else
        begin
            // The period counter pauses while the driver is disabled
            if (expire)
                period_cnt <= '0;
            else if (hc_en)
                period_cnt <= period_cnt + 1'b1;

            // A new expiry in the grant cycle keeps the request pending
            if (expire)
                pending <= 1'b1;
            else if (req.grant)
                pending <= 1'b0;

            // Count the polls issued so far
            if (req.grant)
                poll_cnt <= poll_cnt + 1'b1;
        end
    end

    assign req.request = pending;

    // Source id 2 marks status reads
    assign req.hdr = '{addr:     status_addr,
                       tag:      {2'd2, poll_cnt},
                       req_type: HC_REQ_LINE_READ};

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hdl
hdl/hc_pkg.sv
hdl/hc_read_req_if.sv
hdl/hc_issue_throttle.sv
hdl/hc_line_streamer.sv
hdl/hc_status_poller.sv
hdl/hc_read_arbiter.sv
hdl/hc_read_subsystem.sv
tests/tb_hc_read_subsystem.sv

// ==== tests/tb_hc_read_subsystem.sv ====
/*
 * Testbench for the read request subsystem
 * Random enables, regions and almost-full bursts checked against a cycle model
 */

`timescale 1ns/1ns
`default_nettype none

`include "hc_defs.svh"

module tb_hc_read_subsystem
    import hc_pkg::*;
    ;

    localparam int          NUM_CYCLES = 4000;
    localparam int          CLK_PERIOD = 20;
    localparam logic [31:0] SEED       = 32'hca44_87b6;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      hc_en;
    logic [`HC_ADDR_WIDTH-1:0] reader_base;
    logic [`HC_ADDR_WIDTH-1:0] writer_base;
    logic [`HC_ADDR_WIDTH-1:0] buf_lines;
    logic [`HC_ADDR_WIDTH-1:0] status_addr;
    logic                      tx_almost_full;
    logic                      tx_rd_valid;
    logic [`HC_ADDR_WIDTH-1:0] tx_addr;
    logic [`HC_TAG_WIDTH-1:0]  tx_tag;
    hc_req_type_t              tx_req_type;
    logic                      reader_done;
    logic                      writer_done;

    // The cycle model keeps one variable per register of the design
    logic [`HC_ADDR_WIDTH-1:0] m_r_idx;
    logic [`HC_ADDR_WIDTH-1:0] m_w_idx;
    logic                      m_r_active;
    logic                      m_w_active;
    logic                      m_r_done;
    logic                      m_w_done;
    int                        m_period;
    logic                      m_pending;
    logic [5:0]                m_poll;
    logic                      m_favor_writer;
    int                        m_af_cnt;

    // Expected outputs after the next rising edge
    logic                      exp_valid;
    hc_req_hdr_t               exp_hdr;

    int   errors;
    int   checks;
    int   off_left;
    int   af_left;
    logic prev_af;
    int   af_issues;
    int   reader_reads;
    int   writer_reads;
    int   status_reads;

    hc_read_subsystem DUT
    (
        .clk            (clk),
        .reset          (reset),
        .hc_en          (hc_en),
        .reader_base    (reader_base),
        .writer_base    (writer_base),
        .buf_lines      (buf_lines),
        .status_addr    (status_addr),
        .tx_almost_full (tx_almost_full),
        .tx_rd_valid    (tx_rd_valid),
        .tx_addr        (tx_addr),
        .tx_tag         (tx_tag),
        .tx_req_type    (tx_req_type),
        .reader_done    (reader_done),
        .writer_done    (writer_done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_hdr(input hc_req_hdr_t got, input hc_req_hdr_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL tx_hdr got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_type(input hc_req_type_t got, input hc_req_type_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL tx_req_type got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    // Expected header for line idx of a region, whose tag holds the source id
    // over the line count
    function automatic hc_req_hdr_t line_hdr(input logic [31:0] base,
                                             input logic [31:0] idx,
                                             input logic [1:0]  src);
        return '{addr: base + idx, tag: {src, idx[5:0]}, req_type: HC_REQ_LINE_READ};
    endfunction

    task automatic reset_model();
        m_r_idx        = '0;
        m_w_idx        = '0;
        m_r_active     = 1'b0;
        m_w_active     = 1'b0;
        m_r_done       = 1'b0;
        m_w_done       = 1'b0;
        m_period       = 0;
        m_pending      = 1'b0;
        m_poll         = '0;
        m_favor_writer = 1'b0;
        m_af_cnt       = 0;
        exp_valid      = 1'b0;
        exp_hdr        = '0;
    endtask

    // One streamer across one clock edge
    task automatic step_streamer(input logic grant, inout logic [31:0] idx,
                                 inout logic active, inout logic done);
        if (!hc_en)
        begin
            idx    = '0;
            active = 1'b0;
            done   = 1'b0;
        end
        else if (active)
        begin
            if (grant)
            begin
                if (idx + 32'd1 == buf_lines)
                begin
                    active = 1'b0;
                    done   = 1'b1;
                end
                idx = idx + 32'd1;
            end
        end
        else if (!done)
        begin
            if (buf_lines == '0)
                done = 1'b1;
            else
                active = 1'b1;
        end
    endtask

    // Grants come from this cycle's inputs, then every register steps
    task automatic step_model();
        logic can_issue;
        logic gr;
        logic gw;
        logic gs;
        logic expire;
        can_issue = hc_en && (!tx_almost_full || m_af_cnt < `HC_AF_SLACK);
        gr        = 1'b0;
        gw        = 1'b0;
        gs        = 1'b0;
        exp_hdr   = '0;
        if (m_r_active && (!m_favor_writer || !m_w_active))
        begin
            gr      = can_issue;
            exp_hdr = line_hdr(reader_base, m_r_idx, 2'd0);
        end
        else if (m_w_active)
        begin
            gw      = can_issue;
            exp_hdr = line_hdr(writer_base, m_w_idx, 2'd1);
        end
        else if (m_pending)
        begin
            gs      = can_issue;
            exp_hdr = '{addr: status_addr, tag: {2'd2, m_poll}, req_type: HC_REQ_LINE_READ};
        end
        exp_valid = gr | gw | gs;
        reader_reads += int'(gr);
        writer_reads += int'(gw);
        status_reads += int'(gs);

        if (!tx_almost_full)
            m_af_cnt = 0;
        else if (exp_valid && m_af_cnt < `HC_AF_SLACK)
            m_af_cnt++;

        m_favor_writer = gr;
        step_streamer(gr, m_r_idx, m_r_active, m_r_done);
        step_streamer(gw, m_w_idx, m_w_active, m_w_done);

        expire = hc_en && (m_period == `HC_STATUS_PERIOD - 1);
        if (expire)
            m_period = 0;
        else if (hc_en)
            m_period++;
        if (expire)
            m_pending = 1'b1;
        else if (gs)
            m_pending = 1'b0;
        if (gs)
            m_poll = m_poll + 6'd1;
    endtask

    task automatic check_outputs();
        hc_req_hdr_t got_hdr;
        got_hdr = '{addr: tx_addr, tag: tx_tag, req_type: tx_req_type};
        check_bit("tx_rd_valid", tx_rd_valid, exp_valid);
        if (exp_valid)
            check_hdr(got_hdr, exp_hdr);
        else
            check_type(tx_req_type, HC_REQ_NONE);
        check_bit("reader_done", reader_done, m_r_done);
        check_bit("writer_done", writer_done, m_w_done);

        // Issues granted while almost-full was high must stay within the slack
        if (!prev_af)
            af_issues = 0;
        else if (tx_rd_valid)
            af_issues++;
        if (af_issues > `HC_AF_SLACK)
        begin
            errors++;
            $display("More reads issued during almost-full than the slack allows at %0t",
                     $time);
            af_issues = 0;
        end
    endtask

    task automatic new_region();
        reader_base = $urandom;
        writer_base = $urandom;
        status_addr = $urandom;
        buf_lines   = $urandom_range(1, 40);
    endtask

    task automatic drive_inputs();
        // Enable drops now and then, more often once both regions are done
        if (!hc_en)
        begin
            if (off_left == 0)
                hc_en = 1'b1;
            else
                off_left--;
        end
        else if ($urandom_range(0, 199) == 0 ||
                 (m_r_done && m_w_done && $urandom_range(0, 7) == 0))
        begin
            hc_en    = 1'b0;
            off_left = $urandom_range(0, 4);
            new_region();
        end

        if (af_left > 0)
            af_left--;
        else if ($urandom_range(0, 24) == 0)
            af_left = $urandom_range(1, 10);
        tx_almost_full = (af_left > 0);
    endtask

    initial
    begin
        void'($urandom(SEED));
        errors         = 0;
        checks         = 0;
        off_left       = 2;
        af_left        = 0;
        prev_af        = 1'b0;
        af_issues      = 0;
        reader_reads   = 0;
        writer_reads   = 0;
        status_reads   = 0;
        reset          = 1'b1;
        hc_en          = 1'b0;
        tx_almost_full = 1'b0;
        new_region();
        reset_model();

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int cycle = 0; cycle < NUM_CYCLES; cycle++)
        begin
            check_outputs();
            drive_inputs();
            prev_af = tx_almost_full;
            step_model();
            @(negedge clk);
        end
        check_outputs();

        if (reader_reads == 0 || writer_reads == 0 || status_reads == 0)
        begin
            errors++;
            $display("Some requester never issued a read during the run");
        end

        $display("Checks: %0d  errors: %0d  reads: reader %0d writer %0d status %0d",
                 checks, errors, reader_reads, writer_reads, status_reads);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // Ends a run that outlives the test loop by more than a small margin
    initial
    begin
        #((NUM_CYCLES + 4 + 20) * CLK_PERIOD);
        $display("Watchdog expired before the test loop finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
